/* uart_hub_pkg.sv */
`default_nettype none

package uart_hub_pkg;

	//////////////////////////////////////////////////
	// sizes and timing
	//////////////////////////////////////////////////

	localparam int NUM_CHANNELS = 4;   // serial lines into the hub
	localparam int DATA_BITS    = 8;   // bits per frame, no parity
	localparam int OVERSAMPLE   = 16;  // strobes per bit
	localparam int BAUD_DIVISOR = 4;   // tick cycles per strobe

	// derived widths
	localparam int CHAN_W = $clog2(NUM_CHANNELS);
	localparam int OS_W   = $clog2(OVERSAMPLE);
	localparam int BIT_W  = $clog2(DATA_BITS);
	localparam int DIV_W  = $clog2(BAUD_DIVISOR);

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [DATA_BITS-1:0] data_t;      // one received byte
	typedef logic [CHAN_W-1:0]    chan_t;      // channel index
	typedef logic [OS_W-1:0]      os_count_t;  // strobe count inside a bit
	typedef logic [BIT_W-1:0]     bit_count_t; // data bit index
	typedef logic [DIV_W-1:0]     div_count_t; // strobe divider

	// receiver fsm
	typedef enum logic [1:0]
	{
		IDLE,   // line idle, look for start edge
		START,  // half a bit to the start middle
		DATA,   // one full bit per data sample
		STOP    // sample stop bit
	} rx_state_t;

	// byte as it leaves a receiver or the hub
	typedef struct packed
	{
		chan_t chan;        // filled in by the collector
		data_t data;
		logic  frame_error; // stop bit sampled low
	} rx_byte_t;

endpackage

`default_nettype wire

/* rx_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_front_end import uart_hub_pkg::*;
(
	input  logic                    tick,
	input  logic                    reset,
	input  logic [NUM_CHANNELS-1:0] rx_lines,  // async, idle high
	output logic [NUM_CHANNELS-1:0] rx_sync,   // two cycles behind rx_lines
	output logic                    os_strobe  // one pulse per BAUD_DIVISOR cycles
);

	//////////////////////////////////////////////////
	// line synchronizers
	//////////////////////////////////////////////////

	logic [NUM_CHANNELS-1:0] sync_meta; // first stage, may go metastable

	always_ff @(posedge tick)
	begin
		if (reset)
		begin
			sync_meta <= '1; // lines read idle out of reset
			rx_sync   <= '1;
		end
		else
		begin
			sync_meta <= rx_lines;
			rx_sync   <= sync_meta; // settled copy for the receivers
		end
	end

	//////////////////////////////////////////////////
	// oversample strobe
	//////////////////////////////////////////////////

	// one divider for all channels, so every receiver
	// shares the same timebase
	div_count_t div_count;

	always_ff @(posedge tick)
	begin
		if (reset)
		begin
			div_count <= '0;
			os_strobe <= 1'b0;
		end
		else
		begin
			if (div_count == div_count_t'(BAUD_DIVISOR - 1))
			begin
				div_count <= '0;   // wrap
				os_strobe <= 1'b1; // pulse on the wrap
			end
			else
			begin
				div_count <= div_count + 1'b1;
				os_strobe <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_receiver import uart_hub_pkg::*;
(
	input  logic     tick,
	input  logic     reset,
	input  logic     os_strobe, // shared 16x strobe
	input  logic     rx_bit,    // synchronized serial line
	output logic     done,      // one cycle, byte ready
	output rx_byte_t rx_byte    // valid while done is high
);

	// sample points counted in strobes
	localparam os_count_t OS_HALF = os_count_t'(OVERSAMPLE / 2 - 1); // start middle
	localparam os_count_t OS_LAST = os_count_t'(OVERSAMPLE - 1);     // next bit middle
	localparam bit_count_t BIT_LAST = bit_count_t'(DATA_BITS - 1);

	rx_state_t  state;
	os_count_t  os_count;   // strobes since last sample point
	bit_count_t bit_count;  // data bits taken so far
	data_t      shift_reg;  // byte under assembly
	logic       frame_error;
	logic       mid_bit;    // at the middle of a data or stop bit

	assign mid_bit = os_strobe && (os_count == OS_LAST);

	//////////////////////////////////////////////////
	// control fsm
	//////////////////////////////////////////////////

	always_ff @(posedge tick)
	begin
		if (reset)
		begin
			state     <= IDLE;
			os_count  <= '0;
			bit_count <= '0;
			done      <= 1'b0;
		end
		else
		begin
			done <= 1'b0; // pulse only
			if (os_strobe)
			begin
				case (state)
					IDLE:
					begin
						if (!rx_bit) // falling edge, maybe a start bit
						begin
							state    <= START;
							os_count <= '0;
						end
					end
					START:
					begin
						if (os_count == OS_HALF)
						begin
							os_count  <= '0;
							bit_count <= '0;
							// line back high at the middle means a glitch
							state <= rx_bit ? IDLE : DATA;
						end
						else
							os_count <= os_count + 1'b1;
					end
					DATA:
					begin
						if (os_count == OS_LAST)
						begin
							os_count <= '0;
							if (bit_count == BIT_LAST)
								state <= STOP; // all data bits in
							else
								bit_count <= bit_count + 1'b1;
						end
						else
							os_count <= os_count + 1'b1;
					end
					STOP:
					begin
						if (os_count == OS_LAST)
						begin
							os_count <= '0;
							done     <= 1'b1; // high the cycle after the sample
							state    <= IDLE; // rest of stop bit is idle line
						end
						else
							os_count <= os_count + 1'b1;
					end
					default:
						state <= IDLE;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////

	always_ff @(posedge tick)
	begin
		// lsb arrives first, shifts down to bit 0 by the last sample
		if (mid_bit && state == DATA)
			shift_reg <= {rx_bit, shift_reg[DATA_BITS-1:1]};
		if (mid_bit && state == STOP)
			frame_error <= ~rx_bit; // stop must be high
	end

	// held until the next frame reaches DATA
	assign rx_byte = '{chan: '0, data: shift_reg, frame_error: frame_error};

endmodule

`default_nettype wire

/* rx_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_collector import uart_hub_pkg::*;
(
	input  logic                    tick,
	input  logic                    reset,
	input  logic [NUM_CHANNELS-1:0] done,                   // per receiver pulse
	input  rx_byte_t                rx_bytes [NUM_CHANNELS],
	output logic                    out_valid,              // one cycle strobe
	output rx_byte_t                out_byte                // tagged with its channel
);

	// one byte per channel
	data_t                   slot_data [NUM_CHANNELS];
	logic                    slot_err  [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] slot_full;
	chan_t                   rr_ptr;     // first slot to look at
	logic                    pick_valid;
	chan_t                   pick_idx;

	//////////////////////////////////////////////////
	// round robin pick
	//////////////////////////////////////////////////

	always_comb
	begin : pick
		chan_t cand;
		pick_valid = 1'b0;
		pick_idx   = rr_ptr;
		cand       = rr_ptr;
		for (int k = 0; k < NUM_CHANNELS; k++)
		begin
			cand = chan_t'(rr_ptr + k); // wraps, channel count is a power of two
			if (!pick_valid && slot_full[cand])
			begin
				pick_valid = 1'b1; // first full slot wins
				pick_idx   = cand;
			end
		end
	end

	//////////////////////////////////////////////////
	// flags and pointer
	//////////////////////////////////////////////////

	always_ff @(posedge tick)
	begin
		if (reset)
		begin
			slot_full <= '0;
			rr_ptr    <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= pick_valid;
			if (pick_valid)
			begin
				slot_full[pick_idx] <= 1'b0;        // freed as it goes out
				rr_ptr              <= pick_idx + 1'b1; // start past it next time
			end
			for (int i = 0; i < NUM_CHANNELS; i++)
				if (done[i])
					slot_full[i] <= 1'b1; // never the slot being emitted
		end
	end

	// slot contents and output byte
	always_ff @(posedge tick)
	begin
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			if (done[i])
			begin
				slot_data[i] <= rx_bytes[i].data;
				slot_err[i]  <= rx_bytes[i].frame_error;
			end
		end
		if (pick_valid)
			out_byte <= '{chan: pick_idx, data: slot_data[pick_idx],
				frame_error: slot_err[pick_idx]};
	end

endmodule

`default_nettype wire

/* uart_hub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_hub_top import uart_hub_pkg::*;
(
	input  logic                    tick,
	input  logic                    reset,
	input  logic [NUM_CHANNELS-1:0] rx_lines,  // idle high
	output logic                    out_valid,
	output rx_byte_t                out_byte
);

	logic [NUM_CHANNELS-1:0] rx_sync;   // synchronized lines
	logic                    os_strobe; // shared oversample timebase
	logic [NUM_CHANNELS-1:0] done;
	rx_byte_t                rx_bytes [NUM_CHANNELS];

	//////////////////////////////////////////////////
	// front end
	//////////////////////////////////////////////////

	rx_front_end u_front_end
	(
		.tick      (tick),
		.reset     (reset),
		.rx_lines  (rx_lines),
		.rx_sync   (rx_sync),
		.os_strobe (os_strobe)
	);

	// one receiver per line
	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_rx
		uart_receiver u_receiver
		(
			.tick      (tick),
			.reset     (reset),
			.os_strobe (os_strobe),
			.rx_bit    (rx_sync[i]),
			.done      (done[i]),
			.rx_byte   (rx_bytes[i])
		);
	end

	// merge into one tagged stream
	rx_collector u_collector
	(
		.tick      (tick),
		.reset     (reset),
		.done      (done),
		.rx_bytes  (rx_bytes),
		.out_valid (out_valid),
		.out_byte  (out_byte)
	);

endmodule

`default_nettype wire

/* tb_uart_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_hub import uart_hub_pkg::*;
();

	// one row of the stimulus table
	typedef struct packed
	{
		logic [NUM_CHANNELS-1:0]  mask;       // lines that carry this frame
		data_t [NUM_CHANNELS-1:0] bytes;      // byte per line, ch0 lowest
		logic                     stop_bit;   // low stop bit forces a frame error
		logic                     glitch;     // short low pulse before the frame
		logic [3:0]               glitch_len; // in oversample periods
		logic                     rand_data;  // bytes from the generator
	} frame_rec_t;

	logic                    tick;
	logic                    reset;
	logic [NUM_CHANNELS-1:0] rx_lines;
	logic                    out_valid;
	rx_byte_t                out_byte;

	frame_rec_t  recs [$];
	rx_byte_t    expect_q [NUM_CHANNELS][$]; // per channel, in send order
	logic [31:0] rng_state;
	int          total_got;
	int          frames_planned;

	uart_hub_top DUT
	(
		.tick      (tick),
		.reset     (reset),
		.rx_lines  (rx_lines),
		.out_valid (out_valid),
		.out_byte  (out_byte)
	);

	initial
	begin
		tick = 1'b0;
		forever #4 tick = ~tick; // 8 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic next_drive(input int cycles);
		repeat (cycles) @(posedge tick);
		#1; // inputs move just after the edge
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int pending_count();
		int n;
		n = 0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			n += expect_q[ch].size();
		return n;
	endfunction

	function automatic frame_rec_t make_rec(input logic [NUM_CHANNELS-1:0] mask,
		input data_t [NUM_CHANNELS-1:0] bytes, input logic stop_bit,
		input int glitch_len, input logic rand_data);
		frame_rec_t rec;
		rec.mask       = mask;
		rec.bytes      = bytes;
		rec.stop_bit   = stop_bit;
		rec.glitch     = (glitch_len != 0);
		rec.glitch_len = 4'(glitch_len);
		rec.rand_data  = rand_data;
		return rec;
	endfunction

	task automatic load_table();
		recs.push_back(make_rec(4'b0001, 32'h0000_00A5, 1'b1, 0, 1'b0)); // lone byte, ch0
		recs.push_back(make_rec(4'b1111, 32'h3CC3_817E, 1'b1, 0, 1'b0)); // all lines at once
		recs.push_back(make_rec(4'b0010, 32'h0000_9600, 1'b0, 0, 1'b0)); // stop low, ch1
		recs.push_back(make_rec(4'b1000, 32'h5A00_0000, 1'b1, 3, 1'b0)); // glitch first, ch3
		// back to back random bytes on ch2
		for (int k = 0; k < 8; k++)
			recs.push_back(make_rec(4'b0100, 32'h0, 1'b1, 0, 1'b1));
		frames_planned = 0;
		foreach (recs[r])
			frames_planned += $countones(recs[r].mask);
	endtask

	//////////////////////////////////////////////////
	// serializer
	//////////////////////////////////////////////////

	task automatic send_glitch(input logic [NUM_CHANNELS-1:0] mask, input int len);
		rx_lines = rx_lines & ~mask;  // short low pulse
		next_drive(len * BAUD_DIVISOR);
		rx_lines = rx_lines | mask;
		next_drive(OVERSAMPLE * BAUD_DIVISOR); // settle one bit
	endtask

	task automatic send_frame(input logic [NUM_CHANNELS-1:0] mask,
		input data_t [NUM_CHANNELS-1:0] bytes, input logic stop_bit);
		logic [NUM_CHANNELS-1:0] bits;
		for (int b = 0; b < DATA_BITS + 3; b++) // start, data, stop, idle
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				if (b == 0)
					bits[ch] = 1'b0;           // start
				else if (b <= DATA_BITS)
					bits[ch] = bytes[ch][b-1]; // lsb first
				else if (b == DATA_BITS + 1)
					bits[ch] = stop_bit;
				else
					bits[ch] = 1'b1;           // idle gap
			end
			rx_lines = (rx_lines & ~mask) | (bits & mask);
			next_drive(OVERSAMPLE * BAUD_DIVISOR);
		end
	endtask

	task automatic apply_record(input frame_rec_t rec);
		data_t [NUM_CHANNELS-1:0] bytes;
		rx_byte_t                 exp_byte;
		bytes = rec.bytes;
		if (rec.glitch)
			send_glitch(rec.mask, int'(rec.glitch_len));
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			if (rec.mask[ch])
			begin
				if (rec.rand_data)
				begin
					rng_state = xorshift32(rng_state);
					bytes[ch] = rng_state[7:0];
				end
				exp_byte.chan        = chan_t'(ch);
				exp_byte.data        = bytes[ch];
				exp_byte.frame_error = ~rec.stop_bit; // low stop is an error
				expect_q[ch].push_back(exp_byte);
			end
		end
		send_frame(rec.mask, bytes, rec.stop_bit);
	endtask

	//////////////////////////////////////////////////
	// checks and monitor
	//////////////////////////////////////////////////

	task automatic check_byte(input rx_byte_t expected, input rx_byte_t actual);
		if (actual.data !== expected.data)
			stop_run($sformatf("MISMATCH time %0t out_byte.data ch%0d expected %h got %h",
				$time, actual.chan, expected.data, actual.data));
		else if (actual.frame_error !== expected.frame_error)
			stop_run($sformatf("MISMATCH time %0t out_byte.frame_error ch%0d expected %b got %b",
				$time, actual.chan, expected.frame_error, actual.frame_error));
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected)
			stop_run($sformatf("MISMATCH time %0t %s expected %0d got %0d",
				$time, what, expected, actual));
	endtask

	task automatic wait_drain();
		int waited;
		int ch_late;
		waited  = 0;
		ch_late = 0;
		while (pending_count() != 0 && waited < 12 * OVERSAMPLE * BAUD_DIVISOR)
		begin
			next_drive(1);
			waited++;
		end
		if (pending_count() != 0)
		begin
			for (int ch = NUM_CHANNELS - 1; ch >= 0; ch--)
				if (expect_q[ch].size() != 0)
					ch_late = ch; // lowest waiting channel
			stop_run($sformatf("timeout, byte on channel %0d never arrived", ch_late));
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge tick)
	begin : monitor
		rx_byte_t exp_byte;
		if (out_valid === 1'b1)
		begin
			if (expect_q[out_byte.chan].size() == 0)
				stop_run($sformatf("unexpected output byte %h on channel %0d at %0t",
					out_byte.data, out_byte.chan, $time));
			else
			begin
				exp_byte = expect_q[out_byte.chan].pop_front();
				total_got++;
				check_byte(exp_byte, out_byte);
			end
		end
	end

	initial
	begin
		rx_lines   = '1; // idle
		reset      = 1'b1;
		rng_state  = 32'd52965;
		total_got  = 0;
		load_table();
		repeat (2) @(posedge tick);
		#1;
		reset = 1'b0;
		next_drive(2 * 10 * OVERSAMPLE * BAUD_DIVISOR); // quiet lines, two frame times
		foreach (recs[r])
		begin
			apply_record(recs[r]);
			wait_drain();
		end
		next_drive(10 * OVERSAMPLE * BAUD_DIVISOR); // idle tail, no stray bytes
		check_count("bytes received", frames_planned, total_got);
		if (pending_count() != 0)
			stop_run("bytes still expected after the last frame");
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* list.f */
uart_hub_pkg.sv
rx_front_end.sv
uart_receiver.sv
rx_collector.sv
uart_hub_top.sv
tb_uart_hub.sv

/* run.sh */
#!/bin/sh
# build the hub with its testbench and run it, exit status is the result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module tb_uart_hub -f list.f -o tb_uart_hub \
	&& ./obj_dir/tb_uart_hub \
	|| exit 1
